// File: flist.f
+incdir+src
+incdir+testbench
src/drawer_pkg.sv
src/glyph_pos_if.sv
src/time_digit_splitter.sv
src/cell_locator.sv
src/glyph_renderer.sv
src/image_drawer.sv
testbench/tb_image_drawer.sv

// File: run.sh
#!/bin/sh
# Builds the readout renderer testbench with Verilator and runs it.
# The exit status is the simulator's, non-zero when a check fails.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_image_drawer -f flist.f -o sim_image_drawer
./obj_dir/sim_image_drawer

// File: src/cell_locator.sv
// ==========================================================================
// Finds the strip cell under a pixel and the pixel's position in that cell.
// ==========================================================================
`include "drawer_settings.svh"

module cell_locator (
    input  logic                pixel_clk,
    input  logic                arst_n,
    input  logic                enable,
    input  drawer_pkg::coord_t  row,
    input  drawer_pkg::coord_t  column,
    glyph_pos_if.locator        pos
);

    // Cells left to right are H, colon, M M, colon, S S, colon, m m m.
    localparam int NUM_CELLS = 11;
    localparam logic [NUM_CELLS-1:0] COLON_CELLS = 11'b000_1001_0010;

    localparam drawer_pkg::coord_t ORIGIN_ROW   = drawer_pkg::coord_t'(`DRAW_ORIGIN_ROW);
    localparam drawer_pkg::coord_t ORIGIN_COL   = drawer_pkg::coord_t'(`DRAW_ORIGIN_COL);
    localparam drawer_pkg::coord_t DIGIT_WIDTH  = drawer_pkg::coord_t'(`DRAW_DIGIT_WIDTH);
    localparam drawer_pkg::coord_t DIGIT_HEIGHT = drawer_pkg::coord_t'(`DRAW_DIGIT_HEIGHT);
    localparam drawer_pkg::coord_t COLON_WIDTH  = drawer_pkg::coord_t'(`DRAW_COLON_WIDTH);
    localparam drawer_pkg::coord_t DIGIT_PITCH  =
        drawer_pkg::coord_t'(`DRAW_DIGIT_WIDTH + `DRAW_DIGIT_GAP);

    drawer_pkg::coord_t     rel_row;      // Row relative to the strip top.
    drawer_pkg::coord_t     rel_col;      // Column relative to the strip left.
    drawer_pkg::coord_t     cell_start;   // Running left edge of a cell.
    drawer_pkg::coord_t     cell_draw;    // Drawn columns of that cell.
    drawer_pkg::coord_t     local_col_d;
    drawer_pkg::cell_kind_t kind_d;
    drawer_pkg::digit_sel_t sel_d;
    drawer_pkg::digit_sel_t digit_count;  // Digits left of the current cell.
    logic                   row_hit;
    logic                   col_hit;

    // Pixels above or left of the origin wrap to large values and miss.
    assign rel_row = row - ORIGIN_ROW;
    assign rel_col = column - ORIGIN_COL;
    assign row_hit = rel_row < DIGIT_HEIGHT;

    // Walk the cell boundaries. Gap columns fall between drawn ranges.
    always_comb begin
        cell_start  = '0;
        cell_draw   = '0;
        digit_count = '0;
        col_hit     = 1'b0;
        kind_d      = drawer_pkg::cell_digit;
        sel_d       = '0;
        local_col_d = '0;
        for (int i = 0; i < NUM_CELLS; i++) begin
            cell_draw = COLON_CELLS[i] ? COLON_WIDTH : DIGIT_WIDTH;
            if ((rel_col >= cell_start) && (rel_col < cell_start + cell_draw)) begin
                col_hit     = 1'b1;
                kind_d      = COLON_CELLS[i] ? drawer_pkg::cell_colon
                                             : drawer_pkg::cell_digit;
                sel_d       = digit_count;  // Colons point at the next digit.
                local_col_d = rel_col - cell_start;
            end
            if (COLON_CELLS[i]) begin
                cell_start = cell_start + COLON_WIDTH;
            end else begin
                cell_start  = cell_start + DIGIT_PITCH;
                digit_count = digit_count + 3'd1;
            end
        end
    end

    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            pos.active <= 1'b0;
        end else begin
            pos.active <= enable && row_hit && col_hit;
        end
    end

    // Cell kind, digit and in-cell position of the sampled pixel.
    always_ff @(posedge pixel_clk) begin
        pos.kind      <= kind_d;
        pos.digit_sel <= sel_d;
        pos.local_row <= rel_row;
        pos.local_col <= local_col_d;
    end

    // The renderer's glyph tests assume x inside one glyph.
    local_col_in_glyph: assert property (
        @(posedge pixel_clk) disable iff (!arst_n)
        pos.active |-> (pos.local_col < DIGIT_WIDTH)
    ) else $error("active pixel outside glyph columns");

endmodule

// File: src/drawer_pkg.sv
// ==========================================================================
// Shared types of the readout renderer, used by scoped name.
// ==========================================================================
`include "drawer_settings.svh"

package drawer_pkg;

    // Raster row or column.
    typedef logic [`DRAW_COORD_WIDTH-1:0] coord_t;

    // One decimal digit.
    typedef logic [3:0] bcd_t;

    // Time as shown on the strip, left to right.
    typedef struct packed {
        bcd_t hour;           // Single hour digit.
        bcd_t min_tens;
        bcd_t min_ones;
        bcd_t sec_tens;
        bcd_t sec_ones;
        bcd_t ms_hundreds;
        bcd_t ms_tens;
        bcd_t ms_ones;
    } time_digits_t;

    // What a strip cell holds.
    typedef enum logic {
        cell_digit = 1'b0,
        cell_colon = 1'b1
    } cell_kind_t;

    // Index of a digit in time_digits_t, 0 is the hour.
    typedef logic [2:0] digit_sel_t;

endpackage

// File: src/drawer_settings.svh
// ==========================================================================
// Glyph geometry and strip placement for the stopwatch readout renderer.
// ==========================================================================
`ifndef DRAWER_SETTINGS_SVH
`define DRAWER_SETTINGS_SVH

// Bits of a raster row or column.
`define DRAW_COORD_WIDTH 16

// Size of one digit glyph in pixels.
`define DRAW_DIGIT_WIDTH 40
`define DRAW_DIGIT_HEIGHT 80

// Blank columns after each digit glyph.
`define DRAW_DIGIT_GAP 4

// Width of a colon cell.
`define DRAW_COLON_WIDTH 18

// Top left corner of the strip on the raster.
`define DRAW_ORIGIN_ROW 200
`define DRAW_ORIGIN_COL 120

// Bar thickness, a tenth of the glyph height.
`define DRAW_STROKE 8

`endif

// File: src/glyph_pos_if.sv
// ==========================================================================
// Located pixel, passed from the cell locator to the glyph renderer.
// ==========================================================================
interface glyph_pos_if;

    logic                   active;     // Pixel is in a glyph drawing area.
    drawer_pkg::cell_kind_t kind;       // Digit or colon cell.
    drawer_pkg::digit_sel_t digit_sel;  // Which digit of the time.
    drawer_pkg::coord_t     local_row;  // Row inside the cell.
    drawer_pkg::coord_t     local_col;  // Column inside the cell.

    modport locator (
        output active,
        output kind,
        output digit_sel,
        output local_row,
        output local_col
    );

    modport renderer (
        input active,
        input kind,
        input digit_sel,
        input local_row,
        input local_col
    );

endinterface

// File: src/glyph_renderer.sv
// ==========================================================================
// Draws the bar digits and colon dots for a located pixel, one cycle late.
// ==========================================================================
`include "drawer_settings.svh"

module glyph_renderer (
    input  logic                     pixel_clk,
    input  logic                     arst_n,
    glyph_pos_if.renderer            pos,
    input  drawer_pkg::time_digits_t digits,
    output logic                     r,
    output logic                     g,
    output logic                     b
);

    localparam int WIDTH  = `DRAW_DIGIT_WIDTH;
    localparam int HEIGHT = `DRAW_DIGIT_HEIGHT;
    localparam int STROKE = `DRAW_STROKE;

    // Bar edges in glyph coordinates.
    localparam drawer_pkg::coord_t X_LEFT    = drawer_pkg::coord_t'(STROKE);
    localparam drawer_pkg::coord_t X_RIGHT   = drawer_pkg::coord_t'(WIDTH - STROKE - 1);
    localparam drawer_pkg::coord_t Y_TOP     = drawer_pkg::coord_t'(STROKE);
    localparam drawer_pkg::coord_t Y_BOTTOM  = drawer_pkg::coord_t'(HEIGHT - STROKE);
    localparam drawer_pkg::coord_t Y_HALF    = drawer_pkg::coord_t'(HEIGHT / 2);
    localparam drawer_pkg::coord_t Y_MID_LO  = drawer_pkg::coord_t'(HEIGHT / 2 - STROKE / 2);
    localparam drawer_pkg::coord_t Y_MID_HI  = drawer_pkg::coord_t'(HEIGHT / 2 + STROKE / 2);
    localparam drawer_pkg::coord_t DOT_X_LO  = drawer_pkg::coord_t'(WIDTH / 10);
    localparam drawer_pkg::coord_t DOT_X_HI  = drawer_pkg::coord_t'(7 * WIDTH / 20);
    localparam drawer_pkg::coord_t DOT_Y_TOP = drawer_pkg::coord_t'(HEIGHT / 4);
    localparam drawer_pkg::coord_t DOT_Y_BOT = drawer_pkg::coord_t'(3 * HEIGHT / 4);

    // One bit per bar.
    localparam logic [8:0] TOP         = 9'b0_0000_0001;
    localparam logic [8:0] BOTTOM      = 9'b0_0000_0010;
    localparam logic [8:0] MIDDLE      = 9'b0_0000_0100;
    localparam logic [8:0] LEFT_FULL   = 9'b0_0000_1000;
    localparam logic [8:0] RIGHT_FULL  = 9'b0_0001_0000;
    localparam logic [8:0] LEFT_UPPER  = 9'b0_0010_0000;
    localparam logic [8:0] LEFT_LOWER  = 9'b0_0100_0000;
    localparam logic [8:0] RIGHT_UPPER = 9'b0_1000_0000;
    localparam logic [8:0] RIGHT_LOWER = 9'b1_0000_0000;

    drawer_pkg::bcd_t   cur_digit;
    drawer_pkg::coord_t x;
    drawer_pkg::coord_t y;
    logic [8:0]         bar_hit;   // Bars covering this pixel.
    logic [8:0]         bar_mask;  // Bars lit for the current digit.
    logic               colon_hit;
    logic               lit_d;
    logic               lit_q;

    assign x = pos.local_col;
    assign y = pos.local_row;

    always_comb begin
        case (pos.digit_sel)
            3'd0:    cur_digit = digits.hour;
            3'd1:    cur_digit = digits.min_tens;
            3'd2:    cur_digit = digits.min_ones;
            3'd3:    cur_digit = digits.sec_tens;
            3'd4:    cur_digit = digits.sec_ones;
            3'd5:    cur_digit = digits.ms_hundreds;
            3'd6:    cur_digit = digits.ms_tens;
            default: cur_digit = digits.ms_ones;
        endcase
    end

    // Upper and lower halves share the middle row.
    assign bar_hit = {
        (x >= X_RIGHT) && (y >= Y_HALF),
        (x >= X_RIGHT) && (y <= Y_HALF),
        (x <= X_LEFT) && (y >= Y_HALF),
        (x <= X_LEFT) && (y <= Y_HALF),
        (x >= X_RIGHT),
        (x <= X_LEFT),
        (y >= Y_MID_LO) && (y < Y_MID_HI),
        (y >= Y_BOTTOM),
        (y <= Y_TOP)
    };

    always_comb begin
        case (cur_digit)
            4'd0:    bar_mask = TOP | BOTTOM | LEFT_FULL | RIGHT_FULL;
            4'd1:    bar_mask = RIGHT_FULL;
            4'd2:    bar_mask = TOP | MIDDLE | BOTTOM | LEFT_LOWER | RIGHT_UPPER;
            4'd3:    bar_mask = TOP | MIDDLE | BOTTOM | RIGHT_FULL;
            4'd4:    bar_mask = MIDDLE | LEFT_UPPER | RIGHT_FULL;
            4'd5:    bar_mask = TOP | MIDDLE | BOTTOM | LEFT_UPPER | RIGHT_LOWER;
            4'd6:    bar_mask = TOP | MIDDLE | BOTTOM | LEFT_FULL | RIGHT_LOWER;
            4'd7:    bar_mask = TOP | RIGHT_FULL;
            4'd8:    bar_mask = TOP | MIDDLE | BOTTOM | LEFT_FULL | RIGHT_FULL;
            4'd9:    bar_mask = TOP | MIDDLE | LEFT_UPPER | RIGHT_FULL;
            default: bar_mask = '0;  // Not a decimal digit, draw nothing.
        endcase
    end

    assign colon_hit = (x >= DOT_X_LO) && (x < DOT_X_HI) &&
                       ((y < DOT_Y_TOP) || (y >= DOT_Y_BOT));

    assign lit_d = pos.active &&
                   ((pos.kind == drawer_pkg::cell_colon) ? colon_hit
                                                         : |(bar_mask & bar_hit));

    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            lit_q <= 1'b0;
        end else begin
            lit_q <= lit_d;
        end
    end

    // Readout is white on black only.
    assign r = lit_q;
    assign g = lit_q;
    assign b = lit_q;

    // Digits come from the splitter, the index from the locator.
    digit_is_decimal: assert property (
        @(posedge pixel_clk) disable iff (!arst_n)
        pos.active |-> (cur_digit <= 4'd9)
    ) else $error("selected digit above 9");

endmodule

// File: src/image_drawer.sv
// ==========================================================================
// Stopwatch readout renderer. Returns the pixel colour two clocks after the
// row and column are presented.
// ==========================================================================
module image_drawer (
    input  logic               pixel_clk,
    input  logic               arst_n,
    input  logic [3:0]         hours,
    input  logic [5:0]         minutes,
    input  logic [5:0]         seconds,
    input  logic [9:0]         milliseconds,
    input  logic               enable,
    input  drawer_pkg::coord_t row,
    input  drawer_pkg::coord_t column,
    output logic               r,
    output logic               g,
    output logic               b
);

    drawer_pkg::time_digits_t digits;  // Registered time, aligned with pos_bus.

    glyph_pos_if pos_bus ();

    // Stage 1, time split.
    time_digit_splitter u_splitter (
        .pixel_clk    (pixel_clk),
        .arst_n       (arst_n),
        .hours        (hours),
        .minutes      (minutes),
        .seconds      (seconds),
        .milliseconds (milliseconds),
        .digits       (digits)
    );

    // Stage 1, pixel location.
    cell_locator u_locator (
        .pixel_clk (pixel_clk),
        .arst_n    (arst_n),
        .enable    (enable),
        .row       (row),
        .column    (column),
        .pos       (pos_bus.locator)
    );

    // Stage 2, glyph drawing.
    glyph_renderer u_renderer (
        .pixel_clk (pixel_clk),
        .arst_n    (arst_n),
        .pos       (pos_bus.renderer),
        .digits    (digits),
        .r         (r),
        .g         (g),
        .b         (b)
    );

endmodule

// File: src/time_digit_splitter.sv
// ==========================================================================
// Splits the stopwatch time into eight decimal digits, one cycle of latency.
// ==========================================================================
module time_digit_splitter (
    input  logic                     pixel_clk,
    input  logic                     arst_n,
    input  logic [3:0]               hours,
    input  logic [5:0]               minutes,
    input  logic [5:0]               seconds,
    input  logic [9:0]               milliseconds,
    output drawer_pkg::time_digits_t digits
);

    drawer_pkg::time_digits_t digits_d;
    logic [9:0]               ms_below_100;

    assign ms_below_100 = milliseconds % 10'd100;

    always_comb begin
        digits_d.hour        = hours;
        digits_d.min_tens    = drawer_pkg::bcd_t'(minutes / 6'd10);
        digits_d.min_ones    = drawer_pkg::bcd_t'(minutes % 6'd10);
        digits_d.sec_tens    = drawer_pkg::bcd_t'(seconds / 6'd10);
        digits_d.sec_ones    = drawer_pkg::bcd_t'(seconds % 6'd10);
        digits_d.ms_hundreds = drawer_pkg::bcd_t'(milliseconds / 10'd100);
        digits_d.ms_tens     = drawer_pkg::bcd_t'(ms_below_100 / 10'd10);
        digits_d.ms_ones     = drawer_pkg::bcd_t'(milliseconds % 10'd10);
    end

    // Sampled on the same edge as the pixel entering the locator.
    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            digits <= '0;
        end else begin
            digits <= digits_d;
        end
    end

    // Larger values would give tens or hundreds digits above 5 and 9.
    time_in_range: assert property (
        @(posedge pixel_clk) disable iff (!arst_n)
        (minutes < 6'd60) && (seconds < 6'd60) && (milliseconds < 10'd1000)
    ) else $error("time input out of range");

endmodule

// File: testbench/draw_model.svh
// ==========================================================================
// Readout model for the testbench, included inside the testbench module.
// ==========================================================================
`ifndef DRAW_MODEL_SVH
`define DRAW_MODEL_SVH

`include "drawer_settings.svh"

// Left column of digit p, counted from the strip origin.
function automatic int digit_cell_start(input int p);
    int colons;
    colons = (p >= 5) ? 3 : (p >= 3) ? 2 : (p >= 1) ? 1 : 0;
    return p * (`DRAW_DIGIT_WIDTH + `DRAW_DIGIT_GAP) + colons * `DRAW_COLON_WIDTH;
endfunction

// Colons follow the hour, the minutes and the seconds.
function automatic int colon_cell_start(input int c);
    return digit_cell_start(2 * c + 1) - `DRAW_COLON_WIDTH;
endfunction

function automatic drawer_pkg::time_digits_t split_time(input int h, input int m,
                                                        input int s, input int ms);
    drawer_pkg::time_digits_t d;
    d.hour        = 4'(h);
    d.min_tens    = 4'(m / 10);
    d.min_ones    = 4'(m % 10);
    d.sec_tens    = 4'(s / 10);
    d.sec_ones    = 4'(s % 10);
    d.ms_hundreds = 4'(ms / 100);
    d.ms_tens     = 4'((ms / 10) % 10);
    d.ms_ones     = 4'(ms % 10);
    return d;
endfunction

// Bar shapes on glyph coordinates, x across and y down.
function automatic bit glyph_lit(input drawer_pkg::bcd_t v, input int x, input int y);
    bit top, bottom, middle, lf, rf;
    bit lu, ll, ru, rl;
    top    = (y <= 8);
    bottom = (y >= 72);
    middle = (y >= 36) && (y < 44);
    lf     = (x <= 8);
    rf     = (x >= 31);
    lu     = lf && (y <= 40);
    ll     = lf && (y >= 40);
    ru     = rf && (y <= 40);
    rl     = rf && (y >= 40);
    case (v)
        4'd0:    return top || bottom || lf || rf;
        4'd1:    return rf;
        4'd2:    return top || middle || bottom || ll || ru;
        4'd3:    return top || middle || bottom || rf;
        4'd4:    return middle || lu || rf;
        4'd5:    return top || middle || bottom || lu || rl;
        4'd6:    return top || middle || bottom || lf || rl;
        4'd7:    return top || rf;
        4'd8:    return top || middle || bottom || lf || rf;
        4'd9:    return top || middle || lu || rf;
        default: return 1'b0;
    endcase
endfunction

function automatic bit colon_lit(input int x, input int y);
    return (x >= 4) && (x < 14) && ((y < 20) || (y >= 60));
endfunction

// Expected colour of one raster pixel.
function automatic bit model_pixel(input bit en, input int row, input int col,
                                   input drawer_pkg::time_digits_t d);
    int  x;
    int  y;
    bit  lit;
    lit = 1'b0;
    y   = row - `DRAW_ORIGIN_ROW;
    if (!en || y < 0 || y >= `DRAW_DIGIT_HEIGHT) return 1'b0;
    for (int p = 0; p < 8; p++) begin
        x = col - `DRAW_ORIGIN_COL - digit_cell_start(p);
        if (x >= 0 && x < `DRAW_DIGIT_WIDTH) lit = glyph_lit(d[(7 - p) * 4 +: 4], x, y);
    end
    for (int c = 0; c < 3; c++) begin
        x = col - `DRAW_ORIGIN_COL - colon_cell_start(c);
        if (x >= 0 && x < `DRAW_COLON_WIDTH) lit = colon_lit(x, y);
    end
    return lit;
endfunction

`endif

// File: testbench/tb_image_drawer.sv
// ==========================================================================
// Testbench for the readout renderer. Pixels stream in on every clock and
// are checked two clocks later against the model in draw_model.svh.
// ==========================================================================
`include "drawer_settings.svh"

module tb_image_drawer;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ORG_ROW    = `DRAW_ORIGIN_ROW;
    localparam int ORG_COL    = `DRAW_ORIGIN_COL;
    localparam int STRIP_ROWS = `DRAW_DIGIT_HEIGHT;
    localparam int STRIP_COLS = 8 * (`DRAW_DIGIT_WIDTH + `DRAW_DIGIT_GAP)
                              + 3 * `DRAW_COLON_WIDTH;
    localparam int FULL_SCANS = 3;
    localparam int CELL_SCANS = 72;  // Tens of minutes and seconds stop at 5.
    localparam int PLANNED_CYCLES = 2505 + FULL_SCANS * STRIP_ROWS * STRIP_COLS
        + CELL_SCANS * STRIP_ROWS * `DRAW_DIGIT_WIDTH + 3 * STRIP_ROWS * `DRAW_COLON_WIDTH;
    localparam int CYCLE_LIMIT = PLANNED_CYCLES * 12 / 10;

    logic               pixel_clk;
    logic               arst_n;
    logic [3:0]         hours;
    logic [5:0]         minutes;
    logic [5:0]         seconds;
    logic [9:0]         milliseconds;
    logic               enable;
    drawer_pkg::coord_t row;
    drawer_pkg::coord_t column;
    logic               r;
    logic               g;
    logic               b;

    integer seed;
    int     cycle_count = 0;
    bit     exp_q[$];                          // Pixels still in the pipeline.
    bit     chk_q[$];                          // Compared pixel by pixel.
    int     row_q[$];
    int     col_q[$];
    bit     decode_only = 1'b0;                // Pixels judged by the digit read back.
    bit     scan_img[STRIP_ROWS][STRIP_COLS];  // Last rendered strip.

    `include "draw_model.svh"

    image_drawer uut (.*);

    always #4 pixel_clk = ~pixel_clk;

    always @(posedge pixel_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the test stream ran past %0d cycles.", CYCLE_LIMIT);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        int v;
        v = $random(seed);
        return lo + ((v & 32'h7fff_ffff) % (hi - lo + 1));
    endfunction

    function automatic drawer_pkg::time_digits_t current_digits();
        return split_time(int'(hours), int'(minutes), int'(seconds), int'(milliseconds));
    endfunction

    task automatic check_lit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            $display("tests failed");
            $fatal(1, "pixel compare");
        end
    endtask

    task automatic check_digits(input drawer_pkg::time_digits_t actual,
                                input drawer_pkg::time_digits_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: digits is %h, expected %h", $time, actual, expected);
            $display("tests failed");
            $fatal(1, "digit compare");
        end
    endtask

    task automatic set_time(input int h, input int m, input int s, input int ms);
        hours        = 4'(h);
        minutes      = 6'(m);
        seconds      = 6'(s);
        milliseconds = 10'(ms);
    endtask

    task automatic random_time();
        set_time(rand_range(0, 9), rand_range(0, 59), rand_range(0, 59), rand_range(0, 999));
    endtask

    // Called just after a rising edge, returns just after the next one.
    task automatic send_pixel(input bit en, input int pix_row, input int pix_col);
        bit expected;
        bit checked;
        int img_row;
        int img_col;
        expected = exp_q.pop_front();
        checked  = chk_q.pop_front();
        img_row  = row_q.pop_front() - ORG_ROW;
        img_col  = col_q.pop_front() - ORG_COL;
        if (checked) begin
            check_lit("r", r, expected);
            check_lit("g", g, expected);
            check_lit("b", b, expected);
        end
        if (img_row >= 0 && img_row < STRIP_ROWS && img_col >= 0 && img_col < STRIP_COLS) begin
            scan_img[img_row][img_col] = r;
        end
        enable = en;
        row    = drawer_pkg::coord_t'(pix_row);
        column = drawer_pkg::coord_t'(pix_col);
        exp_q.push_back(model_pixel(en, pix_row, pix_col, current_digits()));
        chk_q.push_back(!decode_only);
        row_q.push_back(pix_row);
        col_q.push_back(pix_col);
        @(posedge pixel_clk);
        #1;
    endtask

    task automatic drain();
        repeat (2) send_pixel(1'b0, 0, 0);
    endtask

    task automatic scan_area(input int row0, input int col0, input int rows, input int cols);
        for (int y = 0; y < rows; y++) begin
            for (int x = 0; x < cols; x++) begin
                send_pixel(1'b1, row0 + y, col0 + x);
            end
        end
    endtask

    // Reads each digit cell of the rendered strip back as a digit or as f where none fits.
    function automatic drawer_pkg::time_digits_t decode_strip();
        drawer_pkg::time_digits_t d;
        bit                       same;
        int                       base;
        d = '1;
        for (int p = 0; p < 8; p++) begin
            base = digit_cell_start(p);
            for (int v = 0; v < 10; v++) begin
                same = 1'b1;
                for (int y = 0; y < STRIP_ROWS; y++) begin
                    for (int x = 0; x < `DRAW_DIGIT_WIDTH; x++) begin
                        if (scan_img[y][base + x] != glyph_lit(4'(v), x, y)) same = 1'b0;
                    end
                end
                if (same) d[(7 - p) * 4 +: 4] = 4'(v);
            end
        end
        return d;
    endfunction

    initial begin
        drawer_pkg::time_digits_t d;
        int                       pix_row;
        int                       pix_col;
        seed      = 32'hf318_2dec;
        pixel_clk = 1'b0;
        arst_n    = 1'b0;
        set_time(8, 0, 0, 0);
        enable    = 1'b1;        // A lit pixel waits during reset.
        row       = drawer_pkg::coord_t'(ORG_ROW);
        column    = drawer_pkg::coord_t'(ORG_COL);
        // The first two outputs after release still come from reset.
        repeat (2) begin
            exp_q.push_back(1'b0);
            chk_q.push_back(1'b1);
            row_q.push_back(-1);
            col_q.push_back(-1);
        end
        repeat (5) begin
            @(posedge pixel_clk);
            #1;
            check_lit("r", r, 1'b0);
            check_lit("g", g, 1'b0);
            check_lit("b", b, 1'b0);
        end
        arst_n = 1'b1;

        random_time();
        repeat (200) begin
            send_pixel(1'b0, ORG_ROW + rand_range(0, STRIP_ROWS - 1),
                       ORG_COL + rand_range(0, STRIP_COLS - 1));
        end

        // Rows off the strip, columns off the strip, then gap columns.
        repeat (300) begin
            pix_row = ORG_ROW + rand_range(0, STRIP_ROWS - 1);
            pix_col = ORG_COL + rand_range(0, STRIP_COLS - 1);
            case (rand_range(0, 2))
                0: pix_row = (rand_range(0, 1) == 1) ? rand_range(0, ORG_ROW - 1)
                                                     : rand_range(ORG_ROW + STRIP_ROWS, 479);
                1: pix_col = (rand_range(0, 1) == 1) ? rand_range(0, ORG_COL - 1)
                                                     : rand_range(ORG_COL + STRIP_COLS, 639);
                default: pix_col = ORG_COL + digit_cell_start(rand_range(0, 7))
                                   + `DRAW_DIGIT_WIDTH + rand_range(0, `DRAW_DIGIT_GAP - 1);
            endcase
            send_pixel(1'b1, pix_row, pix_col);
        end

        repeat (2000) begin
            random_time();
            send_pixel(1'b1, ORG_ROW + rand_range(0, STRIP_ROWS - 1),
                       ORG_COL + rand_range(0, STRIP_COLS - 1));
        end

        // Full scans are judged by the digits read back from the rendered strip.
        repeat (FULL_SCANS) begin
            random_time();
            decode_only = 1'b1;
            scan_area(ORG_ROW, ORG_COL, STRIP_ROWS, STRIP_COLS);
            decode_only = 1'b0;
            drain();
            check_digits(decode_strip(), current_digits());
        end

        // Every digit value in every position that can hold it.
        for (int v = 0; v < 10; v++) begin
            for (int p = 0; p < 8; p++) begin
                if (v < 6 || (p != 1 && p != 3)) begin
                    random_time();
                    d = current_digits();
                    d[(7 - p) * 4 +: 4] = 4'(v);
                    set_time(int'(d.hour), int'(d.min_tens) * 10 + int'(d.min_ones),
                             int'(d.sec_tens) * 10 + int'(d.sec_ones),
                             int'(d.ms_hundreds) * 100 + int'(d.ms_tens) * 10
                             + int'(d.ms_ones));
                    scan_area(ORG_ROW, ORG_COL + digit_cell_start(p), STRIP_ROWS,
                              `DRAW_DIGIT_WIDTH);
                end
            end
        end

        random_time();
        for (int c = 0; c < 3; c++) begin
            scan_area(ORG_ROW, ORG_COL + colon_cell_start(c), STRIP_ROWS, `DRAW_COLON_WIDTH);
        end
        drain();

        $display("all tests passed");
        $finish;
    end

endmodule
